/* verilog.f */
+incdir+testbench
design/aud_pkg.sv
design/play_pkg.sv
design/play_rate_dsp.sv
design/sample_fifo.sv
design/dac_serializer.sv
design/aud_playback_top.sv
testbench/playback_checker.sv
testbench/tb_aud_playback.sv

/* run_sim.sh */
#!/bin/sh
# build and run the playback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_aud_playback -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* testbench/tb_common.svh */
`ifndef TB_COMMON_SVH
`define TB_COMMON_SVH

// shared by the testbench top and the checker

localparam logic [31:0] LCG_SEED = 32'h86b9_8ce1;

// codec timing in i_clk cycles
localparam int CLK_PERIOD_NS    = 8;
localparam int CYCLES_PER_FRAME = 128;   // 2 slots x 16 bclk x 4 clk

// test lengths in frames
localparam int NUM_TESTS    = 7;
localparam int TEST_FRAMES  = 20;
localparam int PAUSE_FRAMES = 12;
localparam int DRAIN_FRAMES = 12;        // FIFO depth plus pipeline slack
localparam int TOTAL_FRAMES = NUM_TESTS * (TEST_FRAMES + DRAIN_FRAMES) + PAUSE_FRAMES;
localparam int TIMEOUT_CYCLES = 2 * TOTAL_FRAMES * CYCLES_PER_FRAME;

function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
endfunction

// SRAM contents, every address bit feeds the pattern
function automatic aud_pkg::sample_t sram_word(input aud_pkg::sram_addr_t addr);
    logic [31:0] s;
    s = lcg_step(lcg_step(LCG_SEED ^ {12'd0, addr}));
    return aud_pkg::sample_t'(s[31:16]);
endfunction

`endif

/* testbench/tb_aud_playback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tb_common.svh"

module tb_aud_playback;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    logic                pause;
    logic                stop;
    logic                fast;
    logic                interp;
    play_pkg::speed_t    speed;
    aud_pkg::sample_t    sram_data;
    aud_pkg::sram_addr_t sram_addr;
    logic                dacdat;
    logic                underrun;
    logic [6:0]          codec_cnt;        // bit 1 is bclk, bit 6 is lrck
    int                  cycles;
    int                  test_num;
    logic                test_end;
    int                  checks;
    int                  errors;

    assign sram_data = sram_word(sram_addr);   // asynchronous read

    aud_playback_top DUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_start         (start),
        .i_pause         (pause),
        .i_stop          (stop),
        .i_fast          (fast),
        .i_interpolation (interp),
        .i_speed         (speed),
        .i_sram_data     (sram_data),
        .o_sram_addr     (sram_addr),
        .i_aud_bclk      (codec_cnt[1]),
        .i_aud_daclrck   (codec_cnt[6]),
        .o_aud_dacdat    (dacdat),
        .o_underrun      (underrun)
    );

    playback_checker u_checker (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_aud_bclk      (codec_cnt[1]),
        .i_aud_daclrck   (codec_cnt[6]),
        .i_aud_dacdat    (dacdat),
        .i_underrun      (underrun),
        .i_fast          (fast),
        .i_interpolation (interp),
        .i_speed         (speed),
        .i_pause         (pause),
        .i_test_num      (test_num),
        .i_test_end      (test_end),
        .o_checks        (checks),
        .o_errors        (errors)
    );

    initial begin
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        codec_cnt <= codec_cnt + 1'b1;     // codec is the clock master
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic wait_frames(input int frames);
        repeat (frames) @(negedge codec_cnt[6]);
    endtask

    task automatic begin_test(input int num, input logic f, input logic ip, input int sp);
        @(negedge clk);
        test_num = num;
        fast     = f;
        interp   = ip;
        speed    = play_pkg::speed_t'(sp);
        start    = 1'b1;
        @(negedge clk);
        start    = 1'b0;
    endtask

    // stop, let the FIFO drain until an underrun frame, then close the test
    task automatic end_test();
        @(negedge clk);
        stop = 1'b1;
        @(negedge clk);
        stop = 1'b0;
        @(posedge underrun);
        @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    task automatic play_test(input int num, input logic f, input logic ip, input int sp);
        begin_test(num, f, ip, sp);
        wait_frames(TEST_FRAMES);
        end_test();
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        pause     = 1'b0;
        stop      = 1'b0;
        fast      = 1'b1;
        interp    = 1'b0;
        speed     = play_pkg::speed_t'(1);
        codec_cnt = '0;
        cycles    = 0;
        test_num  = 0;
        test_end  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        play_test(1, 1'b1, 1'b0, 1);       // normal play
        play_test(2, 1'b1, 1'b0, 3);
        play_test(3, 1'b1, 1'b0, 0);       // zero behaves as 1
        play_test(4, 1'b0, 1'b0, 4);
        play_test(5, 1'b0, 1'b1, 3);

        begin_test(6, 1'b0, 1'b1, 5);      // pause and resume
        wait_frames(TEST_FRAMES / 2);
        pause = 1'b1;
        wait_frames(PAUSE_FRAMES);
        pause = 1'b0;
        wait_frames(TEST_FRAMES / 2);
        end_test();

        play_test(7, 1'b0, 1'b0, 2);       // restart after a mid-phase stop

        @(negedge clk);
        $display("summary: %0d samples checked, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/playback_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tb_common.svh"

module playback_checker (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_aud_bclk,
    input  logic              i_aud_daclrck,
    input  logic              i_aud_dacdat,
    input  logic              i_underrun,
    input  logic              i_fast,
    input  logic              i_interpolation,
    input  play_pkg::speed_t  i_speed,
    input  logic              i_pause,
    input  int                i_test_num,
    input  logic              i_test_end,      // one cycle pulse
    output int                o_checks,
    output int                o_errors
);

    logic             bclk_d;
    logic             lrck_d;
    int               rise_cnt;                // bclk rises since the lrck fall
    logic             frame_ur;
    logic [15:0]      word;
    int               n;                       // output index in the current test
    int               test_checks;
    int               test_errors;
    logic             pause_seen;              // pause requested in this test
    int               pause_ur;                // underrun frames while paused
    int               rc;
    logic [15:0]      got;
    aud_pkg::sample_t exp;

    // expected output n from the fast/slow/linear playback rules
    function automatic aud_pkg::sample_t expected_sample(input int idx, input logic fast,
                                                         input logic interp,
                                                         input play_pkg::speed_t speed);
        int k;
        int i;
        int c;
        int m0;
        int m1;
        int v;
        k = (speed == 0) ? 1 : int'(speed);
        if (fast) begin
            return sram_word(aud_pkg::sram_addr_t'(idx * k));
        end
        i  = idx / k;
        c  = idx % k;
        m0 = int'($signed(sram_word(aud_pkg::sram_addr_t'(i))));
        if (!interp || c == 0) begin
            return aud_pkg::sample_t'(m0);
        end
        m1 = int'($signed(sram_word(aud_pkg::sram_addr_t'(i + 1))));
        v  = m0 + ((m1 - m0) * c) / k;   // int division truncates toward zero
        return aud_pkg::sample_t'(v);
    endfunction

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bclk_d      <= 1'b0;
            lrck_d      <= 1'b0;
            rise_cnt    <= 100;                // no frame in progress
            frame_ur    <= 1'b0;
            word        <= '0;
            n           <= 0;
            test_checks <= 0;
            test_errors <= 0;
            pause_seen  <= 1'b0;
            pause_ur    <= 0;
            o_checks    <= 0;
            o_errors    <= 0;
        end else begin
            bclk_d <= i_aud_bclk;
            lrck_d <= i_aud_daclrck;
            if (i_underrun) begin
                frame_ur <= 1'b1;
            end
            if (i_pause) begin
                pause_seen <= 1'b1;
                if (i_underrun) begin
                    pause_ur <= pause_ur + 1;
                end
            end
            if (lrck_d && !i_aud_daclrck) begin
                rise_cnt <= 0;                 // new frame
                frame_ur <= 1'b0;
            end else if (i_aud_bclk && !bclk_d) begin
                rc = (rise_cnt < 100) ? rise_cnt + 1 : rise_cnt;
                rise_cnt <= rc;
                got = {word[14:0], i_aud_dacdat};
                // serializer output lags the codec clock by about one bit
                if (rc >= 3 && rc <= 18) begin
                    word <= got;
                end
                if (rc == 18) begin
                    if (frame_ur) begin
                        if (got != '0) begin
                            $display("ERROR t=%0t o_aud_dacdat underrun frame: expected %h, got %h",
                                     $time, 16'h0000, got);
                            test_errors <= test_errors + 1;
                            o_errors    <= o_errors + 1;
                        end
                    end else begin
                        exp = expected_sample(n, i_fast, i_interpolation, i_speed);
                        n           <= n + 1;
                        test_checks <= test_checks + 1;
                        o_checks    <= o_checks + 1;
                        if (got != exp) begin
                            $display("ERROR t=%0t o_aud_dacdat sample %0d: expected %h, got %h",
                                     $time, n, exp, got);
                            test_errors <= test_errors + 1;
                            o_errors    <= o_errors + 1;
                        end
                    end
                end
            end
            if (i_test_end) begin
                if (test_checks == 0) begin
                    $display("test %0d: no samples reached the DAC output", i_test_num);
                    o_errors <= o_errors + 1;
                end else if (pause_seen && pause_ur == 0) begin
                    $display("test %0d: no underrun frame while playback was paused",
                             i_test_num);
                    o_errors <= o_errors + 1;
                end else begin
                    $display("test %0d: %0d samples checked, %0d mismatches",
                             i_test_num, test_checks, test_errors);
                end
                n           <= 0;
                test_checks <= 0;
                test_errors <= 0;
                pause_seen  <= 1'b0;
                pause_ur    <= 0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/aud_playback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aud_playback_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic                 i_pause,
    input  logic                 i_stop,
    input  logic                 i_fast,
    input  logic                 i_interpolation,
    input  play_pkg::speed_t     i_speed,
    input  aud_pkg::sample_t     i_sram_data,
    output aud_pkg::sram_addr_t  o_sram_addr,
    input  logic                 i_aud_bclk,
    input  logic                 i_aud_daclrck,
    output logic                 o_aud_dacdat,
    output logic                 o_underrun
);

    logic              smp_valid;     // DSP to FIFO
    logic              smp_ready;
    aud_pkg::sample_t  smp_data;
    logic              rd_valid;      // FIFO to serializer
    logic              rd_ready;
    aud_pkg::sample_t  rd_data;

    play_rate_dsp u_dsp (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_pause         (i_pause),
        .i_stop          (i_stop),
        .i_fast          (i_fast),
        .i_interpolation (i_interpolation),
        .i_speed         (i_speed),
        .i_sram_data     (i_sram_data),
        .o_sram_addr     (o_sram_addr),
        .o_smp_valid     (smp_valid),
        .i_smp_ready     (smp_ready),
        .o_smp_data      (smp_data)
    );

    sample_fifo #(
        .DEPTH (aud_pkg::FIFO_DEPTH)
    ) u_fifo (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_valid (smp_valid),
        .o_wr_ready (smp_ready),
        .i_wr_data  (smp_data),
        .o_rd_valid (rd_valid),
        .i_rd_ready (rd_ready),
        .o_rd_data  (rd_data)
    );

    dac_serializer u_ser (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_aud_bclk    (i_aud_bclk),
        .i_aud_daclrck (i_aud_daclrck),
        .i_rd_valid    (rd_valid),
        .o_rd_ready    (rd_ready),
        .i_rd_data     (rd_data),
        .o_aud_dacdat  (o_aud_dacdat),
        .o_underrun    (o_underrun)
    );

endmodule

`default_nettype wire

/* design/dac_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_serializer (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_aud_bclk,     // from codec master
    input  logic              i_aud_daclrck,  // low for left slot
    input  logic              i_rd_valid,
    output logic              o_rd_ready,
    input  aud_pkg::sample_t  i_rd_data,
    output logic              o_aud_dacdat,
    output logic              o_underrun
);

    localparam int CNT_W = $clog2(aud_pkg::SLOT_BITS + 1);

    logic [2:0]         bclk_q;       // two sync stages plus history
    logic [2:0]         lrck_q;
    logic               bclk_fall;
    logic               lrck_fall;
    logic               lrck_rise;
    aud_pkg::sample_t   frame_word;
    aud_pkg::sample_t   word_r;       // word of the current frame
    aud_pkg::sample_t   shift_r;
    logic [CNT_W-1:0]   bits_r;       // bits still to send in this slot
    logic               dacdat_r;
    logic               underrun_r;

    assign bclk_fall = bclk_q[2] && !bclk_q[1];
    assign lrck_fall = lrck_q[2] && !lrck_q[1];
    assign lrck_rise = !lrck_q[2] && lrck_q[1];

    // one pop per frame, at the start of the left slot
    assign o_rd_ready = lrck_fall;
    assign frame_word = i_rd_valid ? i_rd_data : '0;

    assign o_aud_dacdat = dacdat_r;
    assign o_underrun   = underrun_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bclk_q     <= '0;
            lrck_q     <= '0;
            bits_r     <= '0;
            dacdat_r   <= 1'b0;
            underrun_r <= 1'b0;
        end else begin
            bclk_q     <= {bclk_q[1:0], i_aud_bclk};
            lrck_q     <= {lrck_q[1:0], i_aud_daclrck};
            underrun_r <= lrck_fall && !i_rd_valid;

            // the last bit of a slot goes out on the lrck edge itself
            if (bclk_fall) begin
                dacdat_r <= (bits_r != '0) && shift_r[aud_pkg::SAMPLE_W-1];
            end

            if (lrck_fall || lrck_rise) begin
                bits_r <= CNT_W'(aud_pkg::SLOT_BITS);
            end else if (bclk_fall && (bits_r != '0)) begin
                bits_r <= bits_r - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (lrck_fall) begin
            word_r  <= frame_word;
            shift_r <= frame_word;
        end else if (lrck_rise) begin
            shift_r <= word_r;          // right slot repeats the left word
        end else if (bclk_fall && (bits_r != '0)) begin
            shift_r <= {shift_r[aud_pkg::SAMPLE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* design/sample_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter int DEPTH = aud_pkg::FIFO_DEPTH
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wr_valid,
    output logic              o_wr_ready,
    input  aud_pkg::sample_t  i_wr_data,
    output logic              o_rd_valid,
    input  logic              i_rd_ready,
    output aud_pkg::sample_t  o_rd_data
);

    localparam int AW = $clog2(DEPTH);

    aud_pkg::sample_t mem [DEPTH];
    logic [AW:0]      wr_ptr;         // extra bit tells full from empty
    logic [AW:0]      rd_ptr;
    logic             wr_en;
    logic             rd_en;
    logic             full;
    logic             empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign o_wr_ready = !full;
    assign o_rd_valid = !empty;
    assign wr_en      = i_wr_valid && o_wr_ready;
    assign rd_en      = o_rd_valid && i_rd_ready;

    assign o_rd_data = mem[rd_ptr[AW-1:0]];   // head word, valid when not empty

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/play_rate_dsp.sv */
`timescale 1ns/1ps
`default_nettype none

module play_rate_dsp (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic                 i_pause,
    input  logic                 i_stop,
    input  logic                 i_fast,          // 1 skips samples, 0 stretches
    input  logic                 i_interpolation, // 1 for linear in slow mode
    input  play_pkg::speed_t     i_speed,
    input  aud_pkg::sample_t     i_sram_data,     // async read of o_sram_addr
    output aud_pkg::sram_addr_t  o_sram_addr,
    output logic                 o_smp_valid,
    input  logic                 i_smp_ready,
    output aud_pkg::sample_t     o_smp_data
);

    play_pkg::play_state_e state_r, state_w;
    aud_pkg::sram_addr_t   addr_r, addr_w;   // next source word
    play_pkg::speed_t      cnt_r, cnt_w;     // slow mode phase
    aud_pkg::sample_t      cur_r, cur_w;     // current source sample
    aud_pkg::sample_t      out_r, out_w;     // sample offered to the FIFO

    play_pkg::speed_t      speed_eff;
    play_pkg::speed_t      cnt_inc;
    logic                  xfer;
    logic signed [aud_pkg::SAMPLE_W:0]   diff;
    logic signed [aud_pkg::SAMPLE_W+3:0] scaled;
    aud_pkg::sample_t      lerp;

    assign speed_eff = (i_speed == '0) ? play_pkg::speed_t'(1) : i_speed;
    assign cnt_inc   = cnt_r + play_pkg::speed_t'(1);
    assign xfer      = o_smp_valid && i_smp_ready;

    // linear step toward the next source word, truncates toward zero
    assign diff   = i_sram_data - cur_r;
    assign scaled = diff * $signed({1'b0, cnt_inc}) / $signed({1'b0, speed_eff});
    assign lerp   = aud_pkg::sample_t'(cur_r + scaled);

    assign o_sram_addr = addr_r;
    assign o_smp_valid = (state_r == play_pkg::ST_PLAY);
    assign o_smp_data  = out_r;

    always_comb begin
        state_w = state_r;
        addr_w  = addr_r;
        cnt_w   = cnt_r;
        cur_w   = cur_r;
        out_w   = out_r;

        case (state_r)
            play_pkg::ST_IDLE: begin
                if (i_start) begin                  // address is 0 here
                    cur_w   = i_sram_data;
                    out_w   = i_sram_data;
                    cnt_w   = '0;
                    addr_w  = i_fast ? aud_pkg::sram_addr_t'(speed_eff)
                                     : aud_pkg::sram_addr_t'(1);
                    state_w = play_pkg::ST_PLAY;
                end
            end
            play_pkg::ST_PLAY: begin
                if (xfer) begin
                    if (i_fast) begin
                        cur_w  = i_sram_data;
                        out_w  = i_sram_data;
                        cnt_w  = '0;
                        addr_w = addr_r + aud_pkg::sram_addr_t'(speed_eff);
                    end else if (cnt_inc >= speed_eff) begin
                        // phase wraps, move on to the next source word
                        cnt_w  = '0;
                        cur_w  = i_sram_data;
                        out_w  = i_sram_data;
                        addr_w = addr_r + aud_pkg::sram_addr_t'(1);
                    end else begin
                        cnt_w = cnt_inc;
                        out_w = i_interpolation ? lerp : cur_r;
                    end
                end
                if (i_stop) begin
                    state_w = play_pkg::ST_IDLE;
                    addr_w  = '0;
                    cnt_w   = '0;
                end else if (i_pause) begin
                    state_w = play_pkg::ST_PAUSE;
                end
            end
            play_pkg::ST_PAUSE: begin
                if (i_stop) begin
                    state_w = play_pkg::ST_IDLE;
                    addr_w  = '0;
                    cnt_w   = '0;
                end else if (!i_pause) begin
                    state_w = play_pkg::ST_PLAY;    // resumes with the held sample
                end
            end
            default: begin
                state_w = play_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= play_pkg::ST_IDLE;
            addr_r  <= '0;
            cnt_r   <= '0;
        end else begin
            state_r <= state_w;
            addr_r  <= addr_w;
            cnt_r   <= cnt_w;
        end
    end

    always_ff @(posedge i_clk) begin
        cur_r <= cur_w;
        out_r <= out_w;
    end

endmodule

`default_nettype wire

/* design/play_pkg.sv */
`default_nettype none

package play_pkg;

    // speed factor 1 to 7, zero behaves as 1
    localparam int SPEED_W = 3;
    typedef logic [SPEED_W-1:0] speed_t;

    // player FSM encoding
    localparam int STATE_W = 2;
    typedef enum logic [STATE_W-1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2
    } play_state_e;

endpackage

`default_nettype wire

/* design/aud_pkg.sv */
`default_nettype none

package aud_pkg;

    // audio sample format
    localparam int SAMPLE_W = 16;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // external SRAM holds one sample per word
    localparam int ADDR_W = 20;
    typedef logic [ADDR_W-1:0] sram_addr_t;

    // sample buffer between DSP and codec, must be a power of two
    localparam int FIFO_DEPTH = 8;

    // bit clocks in one left or right slot
    localparam int SLOT_BITS = 16;

endpackage

`default_nettype wire
